//--- rtl/uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  // ---------------------------------------------------------------------------
  // serial timing
  // ---------------------------------------------------------------------------
  localparam int BIT_CYCLES = 16;             // 434 for 50 MHz at 115200 baud
  localparam int HALF_BIT   = BIT_CYCLES / 2;  // receiver sample offset
  localparam int GAP_CYCLES = 100;            // idle cycles between write frames
  localparam int FRAME_BITS = 11;             // start, 8 data, parity, stop

  // ---------------------------------------------------------------------------
  // vector types
  // ---------------------------------------------------------------------------
  typedef logic [15:0]                     cmd_t;  // [15] write, [14:8] addr, [7:0] data
  typedef logic [7:0]                      byte_t;
  typedef logic [$clog2(BIT_CYCLES)-1:0]   baud_cnt_t;
  typedef logic [3:0]                      bit_idx_t;
  typedef logic [7:0]                      gap_cnt_t;

  typedef enum logic [2:0] {
    st_idle,
    st_send_lo,    // write, data byte
    st_gap,
    st_send_hi,    // write, flag and address byte
    st_send_addr,  // read, flag and address byte
    st_wait_reply,
    st_reply
  } ctrl_state_e;

  // one received frame
  typedef struct packed {
    byte_t data;
    logic  parity_err;
    logic  stop_err;
  } rx_result_t;

endpackage

`default_nettype wire

//--- rtl/uart_frame_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_frame_tx
  import uart_cmd_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  tx_start,
  input  wire byte_t tx_byte,
  output logic       tx,
  output logic       tx_done,
  output logic       busy
);

  logic [FRAME_BITS-1:0] frame_q;
  baud_cnt_t             baud_cnt;
  bit_idx_t              bit_idx;
  logic                  bit_end;
  logic                  load;

  assign load    = tx_start && !busy;
  assign bit_end = busy && (baud_cnt == baud_cnt_t'(BIT_CYCLES - 1));

  // high during the last cycle of the stop bit
  assign tx_done = bit_end && (bit_idx == bit_idx_t'(FRAME_BITS - 1));

  // ---------------------------------------------------------------------------
  // bit timing and line driver
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (load)
    begin
      tx       <= 1'b0;  // start bit
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (tx_done)
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        bit_idx <= bit_idx + 4'd1;
        tx      <= frame_q[1];
      end
    end
    else if (busy)
    begin
      baud_cnt <= baud_cnt + baud_cnt_t'(1);
    end
  end

  // frame register, bit 0 is the start bit
  always_ff @(posedge clk)
  begin
    if (load)
      frame_q <= {1'b1, ~^tx_byte, tx_byte, 1'b0};  // stop, odd parity, data, start
    else if (bit_end)
      frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};
  end

endmodule

`default_nettype wire

//--- rtl/uart_frame_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_frame_rx
  import uart_cmd_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  rx,
  output logic       rx_done,
  output rx_result_t rx_res
);

  logic      rx_s1;
  logic      rx_s2;
  logic      rx_q;     // previous synchronized level, for edge detection
  logic      active;
  baud_cnt_t baud_cnt;
  bit_idx_t  bit_idx;
  byte_t     data_q;
  logic      parity_q;
  logic      sample;

  // mid-bit strobe
  assign sample = active && (baud_cnt == baud_cnt_t'(HALF_BIT - 1));

  // ---------------------------------------------------------------------------
  // synchronizer, start detection and bit counting
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1    <= 1'b1;
      rx_s2    <= 1'b1;
      rx_q     <= 1'b1;
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_done  <= 1'b0;
    end
    else
    begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_q    <= rx_s2;
      rx_done <= 1'b0;
      if (!active)
      begin
        if (rx_q && !rx_s2)  // falling edge, possible start bit
        begin
          active   <= 1'b1;
          baud_cnt <= '0;
          bit_idx  <= '0;
        end
      end
      else
      begin
        if (baud_cnt == baud_cnt_t'(BIT_CYCLES - 1))
          baud_cnt <= '0;
        else
          baud_cnt <= baud_cnt + baud_cnt_t'(1);
        if (sample)
        begin
          if (bit_idx == 4'd0 && rx_s2)
            active <= 1'b0;  // glitch, start bit gone high again
          else if (bit_idx == bit_idx_t'(FRAME_BITS - 1))
          begin
            active  <= 1'b0;
            rx_done <= 1'b1;
          end
          else
            bit_idx <= bit_idx + 4'd1;
        end
      end
    end
  end

  // data path, lsb first
  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8)
        data_q <= {rx_s2, data_q[7:1]};
      else if (bit_idx == 4'd9)
        parity_q <= rx_s2;
      else if (bit_idx == bit_idx_t'(FRAME_BITS - 1))
      begin
        rx_res.data       <= data_q;
        rx_res.parity_err <= ~^{data_q, parity_q};  // odd parity over data and parity bit
        rx_res.stop_err   <= ~rx_s2;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/uart_cmd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_ctrl
  import uart_cmd_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire cmd_t       cmd_in,
  input  wire logic       cmd_vld,
  output logic            cmd_rdy,
  output logic            tx_start,
  output byte_t           tx_byte,
  input  wire logic       tx_done,
  input  wire logic       rx_done,
  input  wire rx_result_t rx_res,
  output rx_result_t      read_data,
  output logic            read_rdy
);

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  cmd_t        cmd_q;
  gap_cnt_t    gap_cnt;
  logic        accept;
  logic        gap_end;

  // a new command is also taken in the cycle the reply is returned
  assign cmd_rdy  = (state == st_idle) || (state == st_reply);
  assign read_rdy = (state == st_reply);
  assign accept   = cmd_rdy && cmd_vld;

  // line goes low one cycle after tx_start, so leave the gap one cycle early
  assign gap_end  = (gap_cnt == gap_cnt_t'(GAP_CYCLES - 2));

  assign tx_byte  = (state == st_send_lo) ? cmd_q[7:0] : cmd_q[15:8];

  // ---------------------------------------------------------------------------
  // next state
  // ---------------------------------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle, st_reply:
        if (accept)
          state_nxt = cmd_in[15] ? st_send_lo : st_send_addr;
        else
          state_nxt = st_idle;
      st_send_lo:
        if (tx_done)
          state_nxt = st_gap;
      st_gap:
        if (gap_end)
          state_nxt = st_send_hi;
      st_send_hi:
        if (tx_done)
          state_nxt = st_idle;
      st_send_addr:
        if (tx_done)
          state_nxt = st_wait_reply;
      st_wait_reply:
        if (rx_done)
          state_nxt = st_reply;
      default:
        state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      tx_start <= 1'b0;
      gap_cnt  <= '0;
    end
    else
    begin
      state    <= state_nxt;
      // strobe in the first cycle of every sending state
      tx_start <= (state_nxt != state) &&
                  (state_nxt inside {st_send_lo, st_send_hi, st_send_addr});
      if (state == st_gap)
        gap_cnt <= gap_cnt + gap_cnt_t'(1);
      else
        gap_cnt <= '0;
    end
  end

  // ---------------------------------------------------------------------------
  // command and reply registers
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_data <= '0;
    else if (state == st_wait_reply && rx_done)
      read_data <= rx_res;  // held until the next read completes
  end

endmodule

`default_nettype wire

//--- rtl/uart_cmd_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_top
  import uart_cmd_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire cmd_t  cmd_in,
  input  wire logic  cmd_vld,
  output logic       cmd_rdy,
  input  wire logic  rx,
  output logic       tx,
  output rx_result_t read_data,
  output logic       read_rdy
);

  logic       tx_start;
  byte_t      tx_byte;
  logic       tx_done;
  logic       tx_busy;  // frame on the line
  logic       rx_done;
  rx_result_t rx_res;

  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_done   (rx_done),
    .rx_res    (rx_res),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  uart_frame_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done),
    .busy     (tx_busy)
  );

  uart_frame_rx u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_done (rx_done),
    .rx_res  (rx_res)
  );

endmodule

`default_nettype wire

//--- verification/uart_cmd_assert.sv
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_assert
(
  input wire logic clk,
  input wire logic rst_n,
  input wire logic tx,
  input wire logic tx_busy,
  input wire logic cmd_rdy,
  input wire logic read_rdy
);

  // line idle and command port open when reset is released
  a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> (tx && cmd_rdy && !read_rdy))
    else $error("tx or cmd_rdy not idle when reset was released");

  a_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy high for two cycles");

  // no new command while a frame is on the line
  a_busy_rdy: assert property (@(posedge clk) disable iff (!rst_n) tx_busy |-> !cmd_rdy)
    else $error("cmd_rdy high while a frame is on tx");

endmodule

bind uart_cmd_top uart_cmd_assert u_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .tx       (tx),
  .tx_busy  (tx_busy),
  .cmd_rdy  (cmd_rdy),
  .read_rdy (read_rdy)
);

`default_nettype wire

//--- verification/tb_uart_cmd.sv
`timescale 1ns/10ps
`default_nettype none

module tb_uart_cmd
  import uart_cmd_pkg::*;
();

  localparam int NUM_CMDS       = 60;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * (3 * FRAME_BITS * BIT_CYCLES + GAP_CYCLES) * 2;

  logic       clk;
  logic       rst_n;
  cmd_t       cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  rx_result_t read_data;
  logic       read_rdy;

  integer     seed;
  int         cycle_cnt = 0;
  int         hs_cnt = 0;     // accepted handshakes
  int         rdy_cnt = 0;    // read_rdy pulses
  rx_result_t frames[$];      // frames decoded from tx
  int         frame_cyc[$];   // cycle of each start bit

  uart_cmd_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  always #4 clk = ~clk;

  // ---------------------------------------------------------------------------
  // error reporting and compare tasks
  // ---------------------------------------------------------------------------
  task automatic report_error(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s got %02h expected %02h", what, got, exp));
  endtask

  task automatic check_cmd(input cmd_t got, input cmd_t exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s got %04h expected %04h", what, got, exp));
  endtask

  task automatic check_result(input rx_result_t got, input rx_result_t exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s got data %02h perr %0b serr %0b, expected %02h %0b %0b",
                             what, got.data, got.parity_err, got.stop_err,
                             exp.data, exp.parity_err, exp.stop_err));
  endtask

  function automatic logic coin_flip();
    return 1'($random(seed));
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // ---------------------------------------------------------------------------
  // serial slave: rx encoder and tx decoder
  // ---------------------------------------------------------------------------
  task automatic send_rx_frame(input byte_t d, input logic bad_par, input logic bad_stop,
                               output rx_result_t sent);
    logic [FRAME_BITS-1:0] bits;
    int                    i;
    bits = {~bad_stop, (~^d) ^ bad_par, d, 1'b0};  // stop, parity, data, start
    for (i = 0; i < FRAME_BITS; i++)
    begin
      rx = bits[i];
      repeat (BIT_CYCLES) @(negedge clk);
    end
    rx = 1'b1;
    sent.data       = d;
    sent.parity_err = bad_par;
    sent.stop_err   = bad_stop;
  endtask

  initial
  begin : frame_decoder
    byte_t      data;
    logic       par;
    logic       stop;
    rx_result_t f;
    int         start_cyc;
    int         i;
    forever
    begin
      @(negedge clk);
      if (rst_n === 1'b1 && tx === 1'b0)
      begin
        start_cyc = cycle_cnt;
        repeat (HALF_BIT - 1) @(negedge clk);  // middle of the start bit
        if (tx !== 1'b0)
          report_error("start bit on tx ended before mid-bit");
        for (i = 0; i < 8; i++)
        begin
          repeat (BIT_CYCLES) @(negedge clk);
          data[i] = tx;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        par = tx;
        repeat (BIT_CYCLES) @(negedge clk);
        stop = tx;
        f.data       = data;
        f.parity_err = ~^{data, par};
        f.stop_err   = ~stop;
        frames.push_back(f);
        frame_cyc.push_back(start_cyc);
      end
    end
  end

  // handshake and pulse counters, watchdog
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cmd_vld && cmd_rdy)
      hs_cnt <= hs_cnt + 1;
    if (read_rdy)
      rdy_cnt <= rdy_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("run timed out after %0d cycles before all commands finished", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  initial
  begin : stimulus
    cmd_t       cmd;
    byte_t      reply;
    rx_result_t f_lo;
    rx_result_t f_hi;
    rx_result_t exp_res;
    int         c0;
    int         c1;
    int         gap;
    int         n;
    int         n_reads;
    int         model_cnt;
    seed      = 32'hfa6b;
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx        = 1'b1;
    n_reads   = 0;
    model_cnt = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (tx !== 1'b1 || cmd_rdy !== 1'b1 || read_rdy !== 1'b0)
      report_error("tx, cmd_rdy or read_rdy not idle after reset");
    check_result(read_data, '0, "read_data after reset");

    for (n = 0; n < NUM_CMDS; n++)
    begin
      while (!cmd_rdy) @(negedge clk);
      if (tx !== 1'b1 || read_rdy !== 1'b0)
        report_error("tx or read_rdy not idle between commands");
      if (frames.size() != 0)
        report_error("unexpected frame seen on tx");
      if (rand_range(0, 3) == 0)
      begin
        // reply with no read pending must be ignored
        send_rx_frame(byte_t'($random(seed)), coin_flip(), 1'b0, exp_res);
        repeat (4) @(negedge clk);
        if (rdy_cnt != n_reads)
          report_error("read_rdy pulsed with no read pending");
      end
      cmd     = cmd_t'($random(seed));
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      @(negedge clk);
      if (cmd_rdy !== 1'b0)
        report_error("cmd_rdy still high after a handshake");
      cmd_in  = cmd_t'($random(seed));  // pulse while busy, must be dropped
      cmd_vld = coin_flip();
      @(negedge clk);
      cmd_vld = 1'b0;
      model_cnt++;

      if (cmd[15])
      begin
        while (frames.size() < 2)
        begin
          cmd_vld = ~cmd_vld;  // dropped while busy
          @(negedge clk);
        end
        cmd_vld = 1'b0;
        f_lo = frames.pop_front();
        f_hi = frames.pop_front();
        c0   = frame_cyc.pop_front();
        c1   = frame_cyc.pop_front();
        check_cmd({f_hi.data, f_lo.data}, cmd, "reassembled write command");
        check_result(f_lo, rx_result_t'({cmd[7:0], 2'b00}), "write data frame");
        check_result(f_hi, rx_result_t'({cmd[15:8], 2'b00}), "write address frame");
        gap = c1 - c0 - FRAME_BITS * BIT_CYCLES;
        if (gap < GAP_CYCLES - BIT_CYCLES || gap > GAP_CYCLES + BIT_CYCLES)
          report_error($sformatf("write gap of %0d cycles, expected %0d", gap, GAP_CYCLES));
      end
      else
      begin
        while (frames.size() < 1)
        begin
          cmd_vld = ~cmd_vld;  // dropped while busy
          @(negedge clk);
        end
        cmd_vld = 1'b0;
        f_hi = frames.pop_front();
        c0   = frame_cyc.pop_front();
        check_result(f_hi, rx_result_t'({cmd[15:8], 2'b00}), "read address frame");
        repeat (rand_range(2, 20)) @(negedge clk);
        reply = byte_t'($random(seed));
        send_rx_frame(reply, coin_flip(), coin_flip(), exp_res);
        n_reads++;
        while (rdy_cnt < n_reads) @(negedge clk);
        repeat (2) @(negedge clk);
        if (rdy_cnt != n_reads)
          report_error("read_rdy pulsed more than once for one read");
        check_byte(read_data.data, reply, "read reply data");
        check_result(read_data, exp_res, "read reply");
        if (frames.size() != 0)
          report_error("a second frame followed the read address frame");
      end
    end

    while (!cmd_rdy) @(negedge clk);
    repeat (4) @(negedge clk);
    if (hs_cnt != model_cnt)
      report_error($sformatf("%0d handshakes but %0d commands seen", hs_cnt, model_cnt));
    else
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tb.f
rtl/uart_cmd_pkg.sv
rtl/uart_frame_tx.sv
rtl/uart_frame_rx.sv
rtl/uart_cmd_ctrl.sv
rtl/uart_cmd_top.sv
verification/uart_cmd_assert.sv
verification/tb_uart_cmd.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_uart_cmd
FILELIST   := tb.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
LOG        := sim.log
FAIL_MSG   := TEST RESULT: FAIL
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
